// ==== include/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// one-hot micro-op kind bit positions.
`define KIND_FENCE 1
`define KIND_CSR   2
`define KIND_STORE 3
`define KIND_LOAD  4
`define KIND_CMO   5

// csr opcodes in op bits 1:0.
`define CSR_OP_RW  2'd1
`define CSR_OP_SET 2'd2
`define CSR_OP_CLR 2'd3

// exception cause reported for bad csr access.
`define EXC_ILLEGAL_INSTR 4'd2

`endif

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

  localparam int PRF_TAG_W = 6;
  localparam int ROB_TAG_W = 6; // msb is the wrap bit.
  localparam int XLEN      = 32;

  typedef struct packed {
    logic [ROB_TAG_W-1:0] rob;
    logic [5:0]           kind; // one-hot as in mem_defs.svh.
    logic [2:0]           op;
    logic [XLEN-1:0]      imm;
    logic [PRF_TAG_W-1:0] rs1;
    logic [PRF_TAG_W-1:0] rs2;
    logic [PRF_TAG_W-1:0] dest;
  } mem_uop_t;

  typedef struct packed {
    logic [ROB_TAG_W-1:0] rob;
    logic                 cmo;
    logic [3:0]           op; // {store, op}.
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      imm;
    logic [PRF_TAG_W-1:0] dest;
  } agu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      data;
    logic [1:0]           size;
    logic [ROB_TAG_W-1:0] rob;
    logic [PRF_TAG_W-1:0] dest;
  } mem_req_t;

  typedef struct packed {
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
    logic [1:0]      opcode;
    logic            wr_en;
  } csr_req_t;

  typedef struct packed {
    logic                 valid;
    logic [PRF_TAG_W-1:0] dest;
    logic [XLEN-1:0]      data;
  } wb_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob;
    logic [3:0]           code;
  } excp_t;

endpackage

// ==== verilog/mem_rr.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_rr import mem_pkg::*; (
  input  logic                 core_clock_i,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  input  logic                 uop_vld_i,
  input  mem_uop_t             uop_i,
  output logic                 busy_o,
  input  logic [ROB_TAG_W-2:0] rob_oldest_i,
  input  logic                 rob_lock_i,
  output logic [PRF_TAG_W-1:0] rs1_tag_o,
  output logic [PRF_TAG_W-1:0] rs2_tag_o,
  input  logic [XLEN-1:0]      rs1_data_i,
  input  logic [XLEN-1:0]      rs2_data_i,
  input  logic                 agu_busy_i,
  output logic                 agu_vld_o,
  output agu_req_t             agu_o,
  output logic                 csr_valid_o,
  output csr_req_t             csr_o,
  input  logic                 csr_done_i,
  input  logic                 csr_excp_i,
  input  logic [XLEN-1:0]      csr_rdata_i,
  input  logic                 sb_empty_i,
  output wb_t                  wb_o,
  output logic                 cmpl_vld_o,
  output logic [ROB_TAG_W-1:0] cmpl_rob_o,
  output excp_t                excp_o
);

  logic            is_load;
  logic            is_store;
  logic            is_cmo;
  logic            is_csr;
  logic            is_fence;
  logic            to_agu;
  logic            is_oldest;
  logic            csr_busy_q;
  logic            fence_busy_q;
  logic            csr_start;
  logic            fence_start;
  logic            fence_done;
  logic            sys_done;
  logic [XLEN-1:0] csr_wdata;

  assign is_load  = uop_i.kind[`KIND_LOAD];
  assign is_store = uop_i.kind[`KIND_STORE];
  assign is_cmo   = uop_i.kind[`KIND_CMO];
  assign is_csr   = uop_i.kind[`KIND_CSR];
  assign is_fence = uop_i.kind[`KIND_FENCE];
  assign to_agu   = is_load | is_store | is_cmo;

  assign rs1_tag_o = uop_i.rs1;
  assign rs2_tag_o = uop_i.rs2;

  // wrap bit ignored against the rob head.
  assign is_oldest = (uop_i.rob[ROB_TAG_W-2:0] == rob_oldest_i) && !rob_lock_i;

  // system ops also wait until nothing sits in the agu stage.
  assign csr_start   = uop_vld_i & is_csr & is_oldest & !csr_busy_q & !agu_vld_o;
  assign fence_start = uop_vld_i & is_fence & is_oldest & !fence_busy_q & !agu_vld_o
                       & !flush_i;
  assign fence_done  = fence_busy_q & sb_empty_i;
  assign sys_done    = (csr_busy_q & csr_done_i) | fence_done;

  assign busy_o = agu_busy_i | (uop_vld_i & (is_csr | is_fence) & !sys_done);

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      agu_vld_o <= 1'b0;
    end else if (flush_i) begin
      agu_vld_o <= 1'b0;
    end else if (!agu_busy_i) begin
      agu_vld_o <= uop_vld_i & to_agu;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (!agu_busy_i && uop_vld_i && to_agu) begin
      agu_o.rob     <= uop_i.rob;
      agu_o.cmo     <= is_cmo;
      agu_o.op      <= {is_store, uop_i.op};
      agu_o.rs1_val <= rs1_data_i;
      agu_o.rs2_val <= is_cmo ? '0 : rs2_data_i; // cmo uses rs1 only.
      agu_o.imm     <= is_cmo ? '0 : uop_i.imm;
      agu_o.dest    <= uop_i.dest;
    end
  end

  always_comb begin
    if (uop_i.op[2]) begin
      csr_wdata = {{(XLEN-5){1'b0}}, uop_i.rs1[4:0]}; // immediate form.
    end else if (uop_i.op[1:0] == `CSR_OP_SET || uop_i.op[1:0] == `CSR_OP_CLR) begin
      csr_wdata = {{(XLEN-5){1'b0}}, rs1_data_i[4:0]};
    end else begin
      csr_wdata = rs1_data_i;
    end
  end

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      csr_busy_q  <= 1'b0;
      csr_valid_o <= 1'b0;
    end else begin
      csr_valid_o <= csr_start;
      if (csr_done_i) begin
        csr_busy_q <= 1'b0;
      end else if (csr_start) begin
        csr_busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (csr_start) begin
      csr_o.addr   <= uop_i.imm[11:0];
      csr_o.data   <= csr_wdata;
      csr_o.opcode <= uop_i.op[1:0];
      csr_o.wr_en  <= uop_i.imm[12] | uop_i.op[2]; // imm[12] marks a nonzero rs1 field.
    end
  end

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fence_busy_q <= 1'b0;
    end else if (fence_busy_q) begin
      if (sb_empty_i) begin
        fence_busy_q <= 1'b0;
      end
    end else if (fence_start) begin
      fence_busy_q <= 1'b1;
    end
  end

  assign wb_o.valid = csr_done_i & !csr_excp_i & (uop_i.dest != '0);
  assign wb_o.dest  = uop_i.dest;
  assign wb_o.data  = csr_rdata_i;

  assign cmpl_vld_o = sys_done;
  assign cmpl_rob_o = uop_i.rob;

  assign excp_o.valid = csr_done_i & csr_excp_i;
  assign excp_o.rob   = uop_i.rob;
  assign excp_o.code  = `EXC_ILLEGAL_INSTR;

endmodule

// ==== verilog/phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile import mem_pkg::*; (
  input  logic                 core_clock_i,
  input  logic                 arst_n_i,
  input  logic [PRF_TAG_W-1:0] rs1_tag_i,
  input  logic [PRF_TAG_W-1:0] rs2_tag_i,
  output logic [XLEN-1:0]      rs1_data_o,
  output logic [XLEN-1:0]      rs2_data_o,
  input  wb_t                  wb_i
);

  localparam int              NUM_REGS     = 2**PRF_TAG_W;
  localparam logic [XLEN-1:0] PRELOAD_STEP = 32'h0101_0101;

  logic [XLEN-1:0] regs [NUM_REGS];

  // reset loads register n with n * 0x01010101.
  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= XLEN'(i) * PRELOAD_STEP;
      end
    end else if (wb_i.valid && wb_i.dest != '0) begin
      regs[wb_i.dest] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_tag_i == '0) ? '0 : regs[rs1_tag_i]; // p0 is hardwired zero.
  assign rs2_data_o = (rs2_tag_i == '0) ? '0 : regs[rs2_tag_i];

endmodule

// ==== verilog/mem_agu.sv ====
`timescale 1ns/1ps

module mem_agu import mem_pkg::*; (
  input  logic     core_clock_i,
  input  logic     arst_n_i,
  input  logic     agu_vld_i,
  input  agu_req_t agu_i,
  output logic     agu_busy_o,
  output logic     load_vld_o,
  output mem_req_t load_o,
  output logic     sb_push_o,
  output mem_req_t sb_data_o,
  input  logic     sb_full_i
);

  logic [XLEN-1:0] addr;
  logic            is_load;
  logic            take;

  assign addr    = agu_i.rs1_val + agu_i.imm;
  assign is_load = !agu_i.cmo & !agu_i.op[3];

  // a full store buffer stalls loads as well, so the request is held upstream.
  assign take       = agu_vld_i & !sb_full_i;
  assign agu_busy_o = sb_full_i;

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      load_vld_o <= 1'b0;
    end else begin
      load_vld_o <= take & is_load;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (take && is_load) begin
      load_o.addr <= addr;
      load_o.data <= '0;
      load_o.size <= agu_i.op[1:0];
      load_o.rob  <= agu_i.rob;
      load_o.dest <= agu_i.dest;
    end
  end

  // stores and cmo go straight into the buffer.
  assign sb_push_o      = take & !is_load;
  assign sb_data_o.addr = addr;
  assign sb_data_o.data = agu_i.cmo ? '0 : agu_i.rs2_val;
  assign sb_data_o.size = agu_i.cmo ? 2'd3 : agu_i.op[1:0];
  assign sb_data_o.rob  = agu_i.rob;
  assign sb_data_o.dest = agu_i.dest;

endmodule

// ==== verilog/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer import mem_pkg::*; #(
  parameter int SB_DEPTH = 4
) (
  input  logic     core_clock_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  mem_req_t push_data_i,
  output logic     full_o,
  output logic     empty_o,
  input  logic     mem_ready_i,
  output logic     st_vld_o,
  output mem_req_t st_o
);

  localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
  localparam int CNT_W = $clog2(SB_DEPTH + 1);

  mem_req_t         entries [SB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o  = (count == '0);
  assign full_o   = (count == CNT_W'(SB_DEPTH));
  assign st_vld_o = !empty_o;
  assign st_o     = entries[rd_ptr]; // oldest entry.

  assign do_pop  = st_vld_o & mem_ready_i;
  assign do_push = push_i & (!full_o | do_pop); // full is fine if a slot frees this cycle.

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (do_push) begin
      entries[wr_ptr] <= push_data_i;
    end
  end

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module csr_file import mem_pkg::*; #(
  parameter int CSR_LATENCY = 2
) (
  input  logic            core_clock_i,
  input  logic            arst_n_i,
  input  logic            csr_valid_i,
  input  csr_req_t        csr_i,
  output logic            csr_done_o,
  output logic            csr_excp_o,
  output logic [XLEN-1:0] csr_rdata_o
);

  localparam int          NUM_CSR  = 8;
  localparam logic [11:0] CSR_BASE = 12'h340;

  logic [XLEN-1:0]        csr_q [NUM_CSR];
  logic                   hit;
  logic [2:0]             idx;
  logic [XLEN-1:0]        old_val;
  logic [XLEN-1:0]        new_val;
  logic [CSR_LATENCY-1:0] vld_pipe;
  logic [CSR_LATENCY-1:0] excp_pipe;
  logic [XLEN-1:0]        data_pipe [CSR_LATENCY];

  assign hit     = (csr_i.addr[11:3] == CSR_BASE[11:3]); // 0x340 to 0x347.
  assign idx     = csr_i.addr[2:0];
  assign old_val = hit ? csr_q[idx] : '0;

  always_comb begin
    case (csr_i.opcode)
      `CSR_OP_RW:  new_val = csr_i.data;
      `CSR_OP_SET: new_val = old_val | csr_i.data;
      `CSR_OP_CLR: new_val = old_val & ~csr_i.data;
      default:     new_val = old_val;
    endcase
  end

  always_ff @(posedge core_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_CSR; i++) begin
        csr_q[i] <= '0;
      end
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= csr_valid_i;
      for (int i = 1; i < CSR_LATENCY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
      if (csr_valid_i && hit && csr_i.wr_en) begin
        csr_q[idx] <= new_val;
      end
    end
  end

  // result travels alongside the valid bit.
  always_ff @(posedge core_clock_i) begin
    excp_pipe[0] <= !hit;
    data_pipe[0] <= old_val;
    for (int i = 1; i < CSR_LATENCY; i++) begin
      excp_pipe[i] <= excp_pipe[i-1];
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign csr_done_o  = vld_pipe[CSR_LATENCY-1];
  assign csr_excp_o  = excp_pipe[CSR_LATENCY-1];
  assign csr_rdata_o = data_pipe[CSR_LATENCY-1];

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; #(
  parameter int SB_DEPTH    = 4,
  parameter int CSR_LATENCY = 2
) (
  input  logic                 core_clock_i,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  input  logic                 uop_vld_i,
  input  mem_uop_t             uop_i,
  output logic                 busy_o,
  input  logic [ROB_TAG_W-2:0] rob_oldest_i,
  input  logic                 rob_lock_i,
  input  logic                 mem_ready_i,
  output logic                 load_vld_o,
  output mem_req_t             load_o,
  output logic                 st_vld_o,
  output mem_req_t             st_o,
  output wb_t                  wb_o,
  output logic                 cmpl_vld_o,
  output logic [ROB_TAG_W-1:0] cmpl_rob_o,
  output excp_t                excp_o
);

  logic [PRF_TAG_W-1:0] rs1_tag;
  logic [PRF_TAG_W-1:0] rs2_tag;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic                 agu_busy;
  logic                 agu_vld;
  agu_req_t             agu_req;
  logic                 csr_valid;
  csr_req_t             csr_req;
  logic                 csr_done;
  logic                 csr_excp;
  logic [XLEN-1:0]      csr_rdata;
  logic                 sb_push;
  mem_req_t             sb_data;
  logic                 sb_full;
  logic                 sb_empty;

  mem_rr u_rr (
    .core_clock_i, .arst_n_i, .flush_i, .uop_vld_i, .uop_i, .busy_o,
    .rob_oldest_i, .rob_lock_i,
    .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .agu_busy_i(agu_busy), .agu_vld_o(agu_vld), .agu_o(agu_req),
    .csr_valid_o(csr_valid), .csr_o(csr_req), .csr_done_i(csr_done),
    .csr_excp_i(csr_excp), .csr_rdata_i(csr_rdata), .sb_empty_i(sb_empty),
    .wb_o, .cmpl_vld_o, .cmpl_rob_o, .excp_o
  );

  phys_regfile u_prf (
    .core_clock_i, .arst_n_i,
    .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .wb_i(wb_o) // csr old value lands here.
  );

  mem_agu u_agu (
    .core_clock_i, .arst_n_i, .agu_vld_i(agu_vld), .agu_i(agu_req), .agu_busy_o(agu_busy),
    .load_vld_o, .load_o, .sb_push_o(sb_push), .sb_data_o(sb_data), .sb_full_i(sb_full)
  );

  store_buffer #(.SB_DEPTH(SB_DEPTH)) u_sb (
    .core_clock_i, .arst_n_i, .push_i(sb_push), .push_data_i(sb_data),
    .full_o(sb_full), .empty_o(sb_empty), .mem_ready_i, .st_vld_o, .st_o
  );

  csr_file #(.CSR_LATENCY(CSR_LATENCY)) u_csr (
    .core_clock_i, .arst_n_i, .csr_valid_i(csr_valid), .csr_i(csr_req),
    .csr_done_o(csr_done), .csr_excp_o(csr_excp), .csr_rdata_o(csr_rdata)
  );

endmodule

// ==== verif/mem_subsys_sva.sv ====
`timescale 1ns/1ps

module mem_subsys_sva import mem_pkg::*; (
  input logic     core_clock_i,
  input logic     arst_n_i,
  input logic     flush_i,
  input logic     agu_busy_i,
  input logic     agu_vld_i,
  input agu_req_t agu_i,
  input logic     csr_valid_i,
  input logic     sb_full_i,
  input logic     st_vld_i,
  input mem_req_t st_i,
  input logic     mem_ready_i
);

  // a stalled agu request must not move.
  agu_hold_a : assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
    agu_vld_i && agu_busy_i && !flush_i |=> agu_vld_i && $stable(agu_i))
    else $error("agu request changed while agu_busy was high");

  csr_pulse_a : assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
    csr_valid_i |=> !csr_valid_i)
    else $error("csr_valid lasted more than one cycle");

  // a full buffer without a drain keeps its count and its oldest entry.
  sb_overflow_a : assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
    sb_full_i && !(st_vld_i && mem_ready_i) |=> sb_full_i && $stable(st_i))
    else $error("store buffer took an entry while full without a drain");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (
  .core_clock_i, .arst_n_i, .flush_i,
  .agu_busy_i(agu_busy), .agu_vld_i(agu_vld), .agu_i(agu_req),
  .csr_valid_i(csr_valid), .sb_full_i(sb_full),
  .st_vld_i(st_vld_o), .st_i(st_o), .mem_ready_i
);

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_tb import mem_pkg::*; ();

  localparam int SB_DEPTH    = 4;
  localparam int CSR_LATENCY = 2;
  localparam int WAIT_LIMIT  = 2000;

  logic                 core_clock_i;
  logic                 arst_n_i;
  logic                 flush_i;
  logic                 uop_vld_i;
  mem_uop_t             uop_i;
  logic                 busy_o;
  logic [ROB_TAG_W-2:0] rob_oldest_i;
  logic                 rob_lock_i;
  logic                 mem_ready_i;
  logic                 load_vld_o;
  mem_req_t             load_o;
  logic                 st_vld_o;
  mem_req_t             st_o;
  wb_t                  wb_o;
  logic                 cmpl_vld_o;
  logic [ROB_TAG_W-1:0] cmpl_rob_o;
  excp_t                excp_o;

  integer          seed = 1;
  int              ready_pct = 75;
  int              mem_errs;
  int              wb_errs;
  int              excp_errs;
  int              cmpl_errs;
  int              other_errs;
  bit              timed_out;
  logic [XLEN-1:0] model_regs [64];
  logic [XLEN-1:0] model_csr [8];
  mem_req_t        load_q [$];
  mem_req_t        store_q [$];

  mem_subsys_top #(.SB_DEPTH(SB_DEPTH), .CSR_LATENCY(CSR_LATENCY)) DUT (.*);

  always #2 core_clock_i = ~core_clock_i;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [XLEN-1:0] reg_val(input logic [PRF_TAG_W-1:0] tag);
    return (tag == '0) ? '0 : model_regs[tag];
  endfunction

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      mem_errs++;
    end
  endtask

  task automatic check_wb(input wb_t got, input wb_t exp);
    if (got !== exp) begin
      $display("[ERROR] wb_o got %h expected %h", got, exp);
      wb_errs++;
    end
  endtask

  task automatic check_excp(input excp_t got, input excp_t exp);
    if (got !== exp) begin
      $display("[ERROR] excp_o got %h expected %h", got, exp);
      excp_errs++;
    end
  endtask

  task automatic check_cmpl(input logic vld, input logic [ROB_TAG_W-1:0] got,
                            input logic [ROB_TAG_W-1:0] exp);
    if (vld !== 1'b1 || got !== exp) begin
      $display("[ERROR] cmpl_vld_o/cmpl_rob_o got %h/%h expected 1/%h", vld, got, exp);
      cmpl_errs++;
    end
  endtask

  // drain side of the memory ports sampled mid-cycle.
  always @(negedge core_clock_i) begin
    if (arst_n_i && load_vld_o) begin
      if (load_q.size() == 0) begin
        $display("unexpected load issued to address %h", load_o.addr);
        other_errs++;
      end else begin
        check_mem_req("load_o", load_o, load_q.pop_front());
      end
    end
    if (arst_n_i && st_vld_o && mem_ready_i) begin
      if (store_q.size() == 0) begin
        $display("unexpected store drained to address %h", st_o.addr);
        other_errs++;
      end else begin
        check_mem_req("st_o", st_o, store_q.pop_front());
      end
    end
  end

  always @(posedge core_clock_i) begin
    mem_ready_i <= ((rand32() & 32'h7fff_ffff) % 100) < ready_pct;
  end

  // presents a micro-op and returns in the cycle before it is accepted.
  task automatic issue_uop(input mem_uop_t u, input logic flush);
    int cnt;
    cnt = 0;
    @(posedge core_clock_i);
    uop_vld_i    <= 1'b1;
    uop_i        <= u;
    flush_i      <= flush;
    rob_oldest_i <= u.rob[ROB_TAG_W-2:0];
    @(negedge core_clock_i);
    while (busy_o && !timed_out) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("timed out waiting for busy_o to drop");
        timed_out = 1'b1;
        other_errs++;
      end else begin
        @(negedge core_clock_i);
      end
    end
  endtask

  function automatic mem_uop_t rand_uop(input int kind_bit);
    mem_uop_t   u;
    logic [31:0] r;
    r      = rand32();
    u.rob  = r[5:0];
    u.op   = r[8:6];
    u.rs1  = r[14:9];
    u.rs2  = r[20:15];
    u.dest = r[26:21];
    u.kind = 6'b1 << kind_bit;
    u.imm  = rand32();
    return u;
  endfunction

  task automatic mem_op(input int kind_bit, input logic flush);
    mem_uop_t u;
    mem_req_t e;
    u      = rand_uop(kind_bit);
    e.addr = reg_val(u.rs1) + ((kind_bit == `KIND_CMO) ? '0 : u.imm);
    e.data = (kind_bit == `KIND_STORE) ? reg_val(u.rs2) : '0;
    e.size = (kind_bit == `KIND_CMO) ? 2'd3 : u.op[1:0];
    e.rob  = u.rob;
    e.dest = u.dest;
    issue_uop(u, flush);
    if (flush) begin
      return; // flush in the accept cycle keeps it off load_o.
    end
    if (kind_bit == `KIND_LOAD) begin
      load_q.push_back(e);
    end else begin
      store_q.push_back(e);
    end
  endtask

  task automatic csr_op(input logic [11:0] addr, input logic [2:0] op, input logic wr_flag,
                        input logic [PRF_TAG_W-1:0] dest);
    mem_uop_t        u;
    logic [XLEN-1:0] src;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] nxt;
    logic            hit;
    u        = rand_uop(`KIND_CSR);
    u.op     = op;
    u.imm    = {19'd0, wr_flag, addr};
    u.dest   = dest;
    src      = reg_val(u.rs1);
    hit      = (addr[11:3] == 9'h068);
    old      = hit ? model_csr[addr[2:0]] : '0;
    if (op[2]) begin
      wdata = {27'd0, u.rs1[4:0]};
    end else if (op[1:0] != `CSR_OP_RW) begin
      wdata = {27'd0, src[4:0]};
    end else begin
      wdata = src;
    end
    case (op[1:0])
      `CSR_OP_SET: nxt = old | wdata;
      `CSR_OP_CLR: nxt = old & ~wdata;
      default:     nxt = wdata;
    endcase
    issue_uop(u, 1'b0);
    check_wb(wb_o, '{valid: hit && dest != '0, dest: dest, data: old});
    check_excp(excp_o, '{valid: !hit, rob: u.rob, code: `EXC_ILLEGAL_INSTR});
    check_cmpl(cmpl_vld_o, cmpl_rob_o, u.rob);
    if (hit && (wr_flag || op[2])) begin
      model_csr[addr[2:0]] = nxt;
    end
    if (hit && dest != '0) begin
      model_regs[dest] = old;
    end
  endtask

  task automatic fence_op();
    mem_uop_t u;
    u = rand_uop(`KIND_FENCE);
    issue_uop(u, 1'b0);
    if (store_q.size() != 0) begin
      $display("fence completed with %0d earlier stores not yet drained", store_q.size());
      other_errs++;
    end
    check_cmpl(cmpl_vld_o, cmpl_rob_o, u.rob);
  endtask

  initial begin
    logic [31:0] r;
    int          cnt;
    core_clock_i = 1'b0;
    arst_n_i     = 1'b0;
    flush_i      = 1'b0;
    uop_vld_i    = 1'b0;
    uop_i        = '0;
    rob_oldest_i = '0;
    rob_lock_i   = 1'b0;
    mem_ready_i  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      model_regs[i] = 32'(i) * 32'h0101_0101;
    end
    for (int i = 0; i < 8; i++) begin
      model_csr[i] = '0;
    end
    repeat (16) @(posedge core_clock_i);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge core_clock_i);

    for (int i = 0; i < 30; i++) begin
      mem_op(`KIND_LOAD, 1'b0);
    end
    // slow drain fills the store buffer and pushes back.
    for (int i = 0; i < 80; i++) begin
      ready_pct = (i < 40) ? 15 : 60;
      r = rand32();
      mem_op((r[1:0] == 2'd0) ? `KIND_LOAD : (r[2] ? `KIND_CMO : `KIND_STORE), 1'b0);
    end
    ready_pct = 50;
    for (int i = 0; i < 24; i++) begin
      r = rand32();
      csr_op(12'h340 | 12'(r[2:0]), {r[3], (r[5:4] == 2'd0) ? 2'd1 : r[5:4]}, r[6], r[12:7]);
      csr_op(12'h340 | 12'(r[2:0]), 3'd1, 1'b0, 6'd1 + 6'(r[16:13]));
    end
    for (int i = 0; i < 4; i++) begin
      r = rand32();
      csr_op(12'h348 + 12'(r[3:0]), 3'd1, 1'b1, r[9:4]);
      csr_op(12'h340 | 12'(r[2:0]), 3'd1, 1'b0, 6'd20);
    end
    for (int i = 0; i < 4; i++) begin
      ready_pct = 20;
      for (int j = 0; j < 6; j++) begin
        mem_op(`KIND_STORE, 1'b0);
      end
      fence_op();
    end
    ready_pct = 100;
    for (int i = 0; i < 3; i++) begin
      fence_op();
      mem_op(`KIND_LOAD, 1'b1);
      mem_op(`KIND_LOAD, 1'b0);
    end

    @(posedge core_clock_i);
    uop_vld_i <= 1'b0;
    flush_i   <= 1'b0;
    cnt = 0;
    while ((load_q.size() != 0 || store_q.size() != 0) && !timed_out) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("timed out waiting for loads and stores to drain");
        timed_out = 1'b1;
        other_errs++;
      end else begin
        @(negedge core_clock_i);
      end
    end
    repeat (4) @(posedge core_clock_i);

    $display("errors: mem_req=%0d wb=%0d excp=%0d cmpl=%0d other=%0d",
             mem_errs, wb_errs, excp_errs, cmpl_errs, other_errs);
    if (mem_errs + wb_errs + excp_errs + cmpl_errs + other_errs == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/mem_rr.sv
verilog/phys_regfile.sv
verilog/mem_agu.sv
verilog/store_buffer.sv
verilog/csr_file.sv
verilog/mem_subsys_top.sv
verif/mem_subsys_sva.sv
verif/mem_subsys_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mem_subsys_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
